//--- hdl/sha256_pkg.sv
package sha256_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes

	// One SHA-256 block is 16 words
	localparam int block_words = 16;

	// Two blocks of input buffering
	localparam int fifo_words = 32;

	localparam int num_rounds = 64;

	//////////////////////////////////////////////////////////////////////
	// Shared types

	typedef logic [31:0] word_t;

	// Host update
	// Data is left aligned, first byte in bits 31:24
	typedef struct packed {
		word_t      data;
		logic [2:0] nbytes;
	} in_word_t;

	// Working variables a..h with a in the top bits
	// Same layout is used for the digest
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} hash_state_t;

	// Occupancy from 0 to fifo_words inclusive
	typedef logic [$clog2(fifo_words + 1) - 1:0] fifo_count_t;

	//////////////////////////////////////////////////////////////////////
	// Constants

	// Round constants K0..K63
	localparam word_t round_k [0:num_rounds - 1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Standard initial hash value H0
	localparam hash_state_t hash_init = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Rotate right, used by both the schedule and the rounds
	function automatic word_t ror(word_t x, int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

endpackage

//--- hdl/byte_word_fifo.sv
module byte_word_fifo (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    wr,
	input  sha256_pkg::in_word_t    din,
	input  logic                    flush,
	input  logic                    rd,
	output sha256_pkg::word_t       dout,
	output sha256_pkg::fifo_count_t word_count
);

	//////////////////////////////////////////////////////////////////////
	// Byte lane accumulator

	// Leftover bytes from earlier updates, left aligned
	sha256_pkg::word_t acc;
	logic [1:0]        acc_cnt;

	sha256_pkg::word_t acc_keep;
	sha256_pkg::word_t din_keep;
	logic [63:0]       merged;
	logic [2:0]        total;
	logic              push;
	sha256_pkg::word_t push_word;

	always_comb begin
		// Clear unused low bytes of both sources
		acc_keep = acc & ~(32'hffffffff >> {acc_cnt, 3'b000});
		din_keep = din.data & ~(32'hffffffff >> {din.nbytes, 3'b000});
		// New bytes land right after the held ones
		merged = {acc_keep, 32'h0} | ({din_keep, 32'h0} >> {acc_cnt, 3'b000});
		total = {1'b0, acc_cnt} + din.nbytes;
		push = 1'b0;
		push_word = merged[63:32];
		if (wr && total[2])
			push = 1'b1;
		else if (flush && acc_cnt != 2'd0) begin
			// Partial tail word, low bytes already zero
			push = 1'b1;
			push_word = acc_keep;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			acc_cnt <= 2'd0;
		else if (wr)
			acc_cnt <= total[1:0];
		else if (flush)
			acc_cnt <= 2'd0;
	end

	// Remainder moves up once a full word leaves
	always_ff @(posedge clk) begin
		if (wr)
			acc <= total[2] ? merged[31:0] : merged[63:32];
	end

	//////////////////////////////////////////////////////////////////////
	// Word buffer

	sha256_pkg::word_t mem [sha256_pkg::fifo_words];
	logic [$clog2(sha256_pkg::fifo_words) - 1:0] wr_ptr;
	logic [$clog2(sha256_pkg::fifo_words) - 1:0] rd_ptr;
	sha256_pkg::fifo_count_t count;
	logic push_ok;
	logic pop_ok;

	// A push into a full buffer is dropped
	assign push_ok = push && count != sha256_pkg::fifo_count_t'(sha256_pkg::fifo_words);
	assign pop_ok = rd && count != '0;
	assign word_count = count;

	always_ff @(posedge clk) begin
		if (push_ok)
			mem[wr_ptr] <= push_word;
		// Registered read port
		if (rd)
			dout <= mem[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			wr_ptr <= wr_ptr + 1'(push_ok);
			rd_ptr <= rd_ptr + 1'(pop_ok);
			count <= count + sha256_pkg::fifo_count_t'(push_ok)
				- sha256_pkg::fifo_count_t'(pop_ok);
		end
	end

endmodule

//--- hdl/sha256_msg_schedule.sv
module sha256_msg_schedule (
	input  logic              clk,
	input  logic              rst,
	input  logic              load_en,
	input  logic [3:0]        load_idx,
	input  sha256_pkg::word_t load_word,
	input  logic              zero_en,
	input  logic [3:0]        zero_from,
	input  logic              pad_en,
	input  logic [3:0]        pad_word,
	input  logic [1:0]        pad_byte,
	input  logic              len_en,
	input  logic [31:0]       msg_bytes,
	input  logic              round_en,
	output sha256_pkg::word_t w_cur,
	output sha256_pkg::word_t w_next
);

	// Sliding window W[t] .. W[t+15]
	sha256_pkg::word_t w [sha256_pkg::block_words];
	sha256_pkg::word_t sig0;
	sha256_pkg::word_t sig1;
	sha256_pkg::word_t w_ext;

	// Expansion from W[t-16], W[t-15], W[t-7] and W[t-2]
	assign sig0 = sha256_pkg::ror(w[1], 7) ^ sha256_pkg::ror(w[1], 18) ^ (w[1] >> 3);
	assign sig1 = sha256_pkg::ror(w[14], 17) ^ sha256_pkg::ror(w[14], 19) ^ (w[14] >> 10);
	assign w_ext = w[0] + sig0 + w[9] + sig1;

	assign w_cur = w[0];
	assign w_next = w[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < sha256_pkg::block_words; i++)
				w[i] <= '0;
		end else if (round_en) begin
			for (int i = 0; i < sha256_pkg::block_words - 1; i++)
				w[i] <= w[i + 1];
			w[sha256_pkg::block_words - 1] <= w_ext;
		end else begin
			if (load_en)
				w[load_idx] <= load_word;
			// Zero fill past the last data word
			if (zero_en) begin
				for (int i = 0; i < sha256_pkg::block_words; i++)
					if (i >= zero_from)
						w[i] <= '0;
			end
			// 0x80 marker after the last byte, overrides the fill
			if (pad_en)
				w[pad_word][{~pad_byte, 3'b000} +: 8] <= 8'h80;
			// Bit length as a 64 bit big endian value
			if (len_en) begin
				w[14] <= {29'h0, msg_bytes[31:29]};
				w[15] <= {msg_bytes[28:0], 3'b000};
			end
		end
	end

endmodule

//--- hdl/sha256_compress.sv
module sha256_compress (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    init,
	input  logic                    go,
	input  sha256_pkg::word_t       w_cur,
	input  sha256_pkg::word_t       w_next,
	output logic                    round_en,
	output logic                    block_done,
	output sha256_pkg::hash_state_t hash
);

	typedef enum logic [1:0] {
		ph_idle,
		ph_pre,
		ph_round,
		ph_add
	} phase_t;

	phase_t phase;

	// Working variables and saved chaining value
	sha256_pkg::hash_state_t st;
	sha256_pkg::hash_state_t prev;
	sha256_pkg::hash_state_t st_round;
	sha256_pkg::hash_state_t st_sum;

	// h + K[t] + W[t], one round ahead
	sha256_pkg::word_t hkw;
	logic [5:0]        round;
	logic [5:0]        round_nxt;

	sha256_pkg::word_t big_s0;
	sha256_pkg::word_t big_s1;
	sha256_pkg::word_t ch;
	sha256_pkg::word_t maj;
	sha256_pkg::word_t t1;
	sha256_pkg::word_t t2;

	assign round_nxt = round + 6'd1;
	assign round_en = phase == ph_round;
	assign hash = st;

	//////////////////////////////////////////////////////////////////////
	// Round function

	always_comb begin
		big_s1 = sha256_pkg::ror(st.e, 6) ^ sha256_pkg::ror(st.e, 11)
			^ sha256_pkg::ror(st.e, 25);
		ch = (st.e & st.f) ^ (~st.e & st.g);
		t1 = big_s1 + ch + hkw;
		big_s0 = sha256_pkg::ror(st.a, 2) ^ sha256_pkg::ror(st.a, 13)
			^ sha256_pkg::ror(st.a, 22);
		maj = (st.a & st.b) ^ (st.a & st.c) ^ (st.b & st.c);
		t2 = big_s0 + maj;
		st_round = '{a: t1 + t2, b: st.a, c: st.b, d: st.c,
			e: st.d + t1, f: st.e, g: st.f, h: st.g};
	end

	// Feed forward, word by word
	always_comb begin
		for (int i = 0; i < 8; i++)
			st_sum[i * 32 +: 32] = st[i * 32 +: 32] + prev[i * 32 +: 32];
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencing

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= ph_idle;
			block_done <= 1'b0;
		end else begin
			block_done <= 1'b0;
			case (phase)
				ph_idle: if (go) phase <= ph_pre;
				ph_pre: phase <= ph_round;
				ph_round: if (round == 6'(sha256_pkg::num_rounds - 1)) phase <= ph_add;
				default: begin
					phase <= ph_idle;
					block_done <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (phase)
			ph_idle: begin
				if (init)
					st <= sha256_pkg::hash_init;
				if (go)
					prev <= st;
			end
			ph_pre: begin
				hkw <= st.h + sha256_pkg::round_k[0] + w_cur;
				round <= 6'd0;
			end
			ph_round: begin
				st <= st_round;
				// g becomes h and the schedule shifts at this edge
				hkw <= st.g + sha256_pkg::round_k[round_nxt] + w_next;
				round <= round_nxt;
			end
			default: st <= st_sum;
		endcase
	end

endmodule

//--- hdl/sha256_block_ctrl.sv
module sha256_block_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic                    update,
	input  logic [2:0]              nbytes,
	input  logic                    finalize,
	input  sha256_pkg::fifo_count_t word_count,
	input  sha256_pkg::word_t       dout,
	output logic                    rd,
	output logic                    load_en,
	output logic [3:0]              load_idx,
	output sha256_pkg::word_t       load_word,
	output logic                    zero_en,
	output logic [3:0]              zero_from,
	output logic                    pad_en,
	output logic [3:0]              pad_word,
	output logic [1:0]              pad_byte,
	output logic                    len_en,
	output logic [31:0]             msg_bytes,
	output logic                    init,
	output logic                    go,
	output logic                    hash_valid,
	input  logic                    block_done
);

	typedef enum logic [1:0] {
		s_idle,
		s_fill,
		s_pad,
		s_hash
	} state_t;

	state_t state;

	// Words still to request and words loaded into this block
	logic [4:0]  rd_left;
	logic [4:0]  ld_cnt;
	logic        rd_q;
	// Bytes moved into blocks, one extra bit for the tail word
	logic [32:0] hashed_bytes;
	logic        finalizing;
	logic        marker_done;
	logic        last_block;

	logic fill_done;
	logic block_full;
	logic tail_in_block;
	logic len_fits;

	assign fill_done = state == s_fill && rd_left == 5'd0 && !rd_q;
	assign block_full = ld_cnt == 5'(sha256_pkg::block_words);
	// Zero filled tail word went into a full block
	assign tail_in_block = hashed_bytes > {1'b0, msg_bytes};
	// Length fits after the marker when length mod 64 is at most 55
	assign len_fits = marker_done || msg_bytes[5:0] <= 6'd55;

	//////////////////////////////////////////////////////////////////////
	// Schedule writes

	assign rd = state == s_fill && rd_left != 5'd0;
	// FIFO data is one cycle behind rd
	assign load_en = rd_q;
	assign load_idx = ld_cnt[3:0];
	assign load_word = dout;

	assign zero_en = state == s_pad && !block_full;
	assign zero_from = ld_cnt[3:0];
	assign pad_en = state == s_pad && !marker_done;
	assign pad_word = msg_bytes[5:2];
	assign pad_byte = msg_bytes[1:0];
	assign len_en = state == s_pad && len_fits;

	//////////////////////////////////////////////////////////////////////
	// Hash FSM

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			rd_left <= 5'd0;
			ld_cnt <= 5'd0;
			rd_q <= 1'b0;
			hashed_bytes <= 33'd0;
			msg_bytes <= 32'd0;
			finalizing <= 1'b0;
			marker_done <= 1'b0;
			last_block <= 1'b0;
			init <= 1'b0;
			go <= 1'b0;
			hash_valid <= 1'b0;
		end else begin
			init <= start;
			go <= 1'b0;
			hash_valid <= 1'b0;
			rd_q <= rd;
			if (rd)
				rd_left <= rd_left - 5'd1;
			if (rd_q) begin
				ld_cnt <= ld_cnt + 5'd1;
				hashed_bytes <= hashed_bytes + 33'd4;
			end
			if (start) begin
				msg_bytes <= 32'd0;
				hashed_bytes <= 33'd0;
				finalizing <= 1'b0;
				marker_done <= 1'b0;
			end else if (update)
				msg_bytes <= msg_bytes + 32'(nbytes);
			if (finalize)
				finalizing <= 1'b1;
			case (state)
				s_idle: begin
					// Full block ready
					if (word_count >= sha256_pkg::fifo_count_t'(sha256_pkg::block_words)) begin
						rd_left <= 5'(sha256_pkg::block_words);
						ld_cnt <= 5'd0;
						state <= s_fill;
					// Final block with whatever is left, possibly nothing
					end else if (finalizing) begin
						rd_left <= 5'(word_count);
						ld_cnt <= 5'd0;
						state <= s_fill;
					end
				end
				s_fill: begin
					if (fill_done) begin
						if (block_full && !tail_in_block) begin
							go <= 1'b1;
							state <= s_hash;
						end else
							state <= s_pad;
					end
				end
				s_pad: begin
					marker_done <= 1'b1;
					last_block <= len_fits;
					go <= 1'b1;
					state <= s_hash;
				end
				default: begin
					if (block_done) begin
						// Digest is in the compress state by now
						if (last_block) begin
							hash_valid <= 1'b1;
							finalizing <= 1'b0;
							marker_done <= 1'b0;
							last_block <= 1'b0;
						end
						state <= s_idle;
					end
				end
			endcase
		end
	end

endmodule

//--- hdl/streaming_sha256.sv
module streaming_sha256 (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic                    update,
	input  sha256_pkg::in_word_t    data_in,
	input  logic                    finalize,
	output logic                    hash_valid,
	output sha256_pkg::hash_state_t hash
);

	logic                    fifo_rd;
	sha256_pkg::word_t       fifo_dout;
	sha256_pkg::fifo_count_t word_count;

	// Schedule write controls
	logic              load_en;
	logic [3:0]        load_idx;
	sha256_pkg::word_t load_word;
	logic              zero_en;
	logic [3:0]        zero_from;
	logic              pad_en;
	logic [3:0]        pad_word;
	logic [1:0]        pad_byte;
	logic              len_en;
	logic [31:0]       msg_bytes;

	logic              init;
	logic              go;
	logic              round_en;
	logic              block_done;
	sha256_pkg::word_t w_cur;
	sha256_pkg::word_t w_next;

	//////////////////////////////////////////////////////////////////////
	// Input packing and buffering

	// Finalize flushes the partial tail word
	byte_word_fifo u_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr         (update),
		.din        (data_in),
		.flush      (finalize),
		.rd         (fifo_rd),
		.dout       (fifo_dout),
		.word_count (word_count)
	);

	sha256_block_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.update     (update),
		.nbytes     (data_in.nbytes),
		.finalize   (finalize),
		.word_count (word_count),
		.dout       (fifo_dout),
		.rd         (fifo_rd),
		.load_en    (load_en),
		.load_idx   (load_idx),
		.load_word  (load_word),
		.zero_en    (zero_en),
		.zero_from  (zero_from),
		.pad_en     (pad_en),
		.pad_word   (pad_word),
		.pad_byte   (pad_byte),
		.len_en     (len_en),
		.msg_bytes  (msg_bytes),
		.init       (init),
		.go         (go),
		.hash_valid (hash_valid),
		.block_done (block_done)
	);

	//////////////////////////////////////////////////////////////////////
	// Hash datapath

	sha256_msg_schedule u_sched (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_idx  (load_idx),
		.load_word (load_word),
		.zero_en   (zero_en),
		.zero_from (zero_from),
		.pad_en    (pad_en),
		.pad_word  (pad_word),
		.pad_byte  (pad_byte),
		.len_en    (len_en),
		.msg_bytes (msg_bytes),
		.round_en  (round_en),
		.w_cur     (w_cur),
		.w_next    (w_next)
	);

	sha256_compress u_comp (
		.clk        (clk),
		.rst        (rst),
		.init       (init),
		.go         (go),
		.w_cur      (w_cur),
		.w_next     (w_next),
		.round_en   (round_en),
		.block_done (block_done),
		.hash       (hash)
	);

endmodule

//--- verif/sha256_ref_model.svh
`ifndef SHA256_REF_MODEL_SVH
`define SHA256_REF_MODEL_SVH

// Message bytes in order, first byte at index 0
typedef byte unsigned byte_q_t[$];

function automatic logic [31:0] rot_right(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// Plain SHA-256 over a padded copy of the whole message
function automatic sha256_pkg::hash_state_t sha256_of(input byte_q_t msg);
	byte_q_t     padded;
	logic [63:0] bit_len;
	logic [31:0] w [64];
	logic [31:0] hv [8];
	logic [31:0] v [8];
	logic [31:0] s0;
	logic [31:0] s1;
	logic [31:0] t1;
	logic [31:0] t2;
	int          base;

	// Standard initial value H0..H7
	hv = '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

	// Marker, zeros up to 56 mod 64, then the 64 bit length
	padded = msg;
	bit_len = 64'(msg.size()) * 64'd8;
	padded.push_back(8'h80);
	while (padded.size() % 64 != 56)
		padded.push_back(8'h00);
	for (int i = 7; i >= 0; i--)
		padded.push_back(bit_len[i * 8 +: 8]);

	for (int blk = 0; blk < padded.size() / 64; blk++) begin
		base = blk * 64;
		// Big endian words of this block
		for (int t = 0; t < 16; t++)
			w[t] = {padded[base + 4 * t], padded[base + 4 * t + 1],
				padded[base + 4 * t + 2], padded[base + 4 * t + 3]};
		// Full 64 entry expansion
		for (int t = 16; t < 64; t++) begin
			s0 = rot_right(w[t - 15], 7) ^ rot_right(w[t - 15], 18) ^ (w[t - 15] >> 3);
			s1 = rot_right(w[t - 2], 17) ^ rot_right(w[t - 2], 19) ^ (w[t - 2] >> 10);
			w[t] = w[t - 16] + s0 + w[t - 7] + s1;
		end
		// v[0] is a, v[7] is h
		v = hv;
		for (int t = 0; t < 64; t++) begin
			s1 = rot_right(v[4], 6) ^ rot_right(v[4], 11) ^ rot_right(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6]))
				+ sha256_pkg::round_k[t] + w[t];
			s0 = rot_right(v[0], 2) ^ rot_right(v[0], 13) ^ rot_right(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int i = 7; i > 0; i--)
				v[i] = v[i - 1];
			// Old d now sits in e
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			hv[i] = hv[i] + v[i];
	end
	return {hv[0], hv[1], hv[2], hv[3], hv[4], hv[5], hv[6], hv[7]};
endfunction

`endif

//--- verif/streaming_sha256_tb.sv
module streaming_sha256_tb;

	localparam int clk_period = 100;
	// Bytes over all hashes including the partial message before reset
	localparam int total_bytes = 0 + 3 + 56 + 200 + 20 + 70 + 40 + 64;
	localparam int num_tests = 6;
	localparam int watchdog_cycles = total_bytes * 40 + num_tests * 400;
	// Finalize to digest takes a few blocks at most
	localparam int hash_timeout = 1000;

	localparam sha256_pkg::hash_state_t empty_digest =
		256'he3b0c442_98fc1c14_9afbf4c8_996fb924_27ae41e4_649b934c_a495991b_7852b855;
	localparam sha256_pkg::hash_state_t abc_digest =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    start;
	logic                    update;
	sha256_pkg::in_word_t    data_in;
	logic                    finalize;
	logic                    hash_valid;
	sha256_pkg::hash_state_t hash;

	logic [31:0] lfsr;

	`include "sha256_ref_model.svh"

	streaming_sha256 dut0 (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.update     (update),
		.data_in    (data_in),
		.finalize   (finalize),
		.hash_valid (hash_valid),
		.hash       (hash)
	);

	always #(clk_period / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compares

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("=== FAIL ===");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic check_digest(input sha256_pkg::hash_state_t got,
		input sha256_pkg::hash_state_t exp, input string what);
		if (got !== exp)
			fail_now($sformatf("error %0t: %s digest got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_now($sformatf("error %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Random source

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit with the newest bit at the bottom
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic byte_q_t random_message(input int len);
		byte_q_t msg;
		for (int i = 0; i < len; i++)
			msg.push_back(8'(take_bits(8)));
		return msg;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host side driving on the falling edge

	// Caller sits on a falling edge or at time zero
	task automatic apply_reset();
		rst = 1'b1;
		start = 1'b0;
		update = 1'b0;
		finalize = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	endtask

	task automatic start_hash();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// One update every 8 cycles
	task automatic push_chunk(input logic [31:0] data, input int n);
		@(negedge clk);
		update = 1'b1;
		data_in = '{data: data, nbytes: 3'(n)};
		@(negedge clk);
		update = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	task automatic drive_message(input byte_q_t msg, input bit random_widths);
		int          pos;
		int          n;
		logic [31:0] word;
		pos = 0;
		while (pos < msg.size()) begin
			if (random_widths)
				n = int'(take_bits(2)) + 1;
			else
				n = 4;
			if (n > msg.size() - pos)
				n = msg.size() - pos;
			// Unused low lanes carry junk that the core must ignore
			word = 32'hffffffff;
			for (int i = 0; i < n; i++)
				word[31 - 8 * i -: 8] = msg[pos + i];
			push_chunk(word, n);
			pos += n;
		end
	endtask

	task automatic finalize_hash();
		@(negedge clk);
		finalize = 1'b1;
		@(negedge clk);
		finalize = 1'b0;
	endtask

	// Digest is sampled mid cycle on the hash_valid pulse
	task automatic wait_digest(output sha256_pkg::hash_state_t d);
		int cycles;
		cycles = 0;
		while (hash_valid !== 1'b1) begin
			if (cycles == hash_timeout)
				fail_now($sformatf("hash_valid did not arrive within %0d cycles of finalize",
					hash_timeout));
			else begin
				@(negedge clk);
				cycles++;
			end
		end
		d = hash;
		@(negedge clk);
		check_flag(hash_valid, 1'b0, "hash_valid pulse length");
		check_digest(hash, d, "digest held after hash_valid");
	endtask

	task automatic run_hash(input byte_q_t msg, input bit random_widths,
		input string what, output sha256_pkg::hash_state_t got);
		start_hash();
		drive_message(msg, random_widths);
		finalize_hash();
		wait_digest(got);
		check_digest(got, sha256_of(msg), what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_idle_then_empty();
		byte_q_t                 empty;
		sha256_pkg::hash_state_t got;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_flag(hash_valid, 1'b0, "hash_valid while idle after reset");
		end
		check_digest(sha256_of(empty), empty_digest, "reference model for empty input");
		run_hash(empty, 1'b0, "empty message", got);
		check_digest(got, empty_digest, "empty message against known value");
	endtask

	task automatic test_abc();
		byte_q_t                 msg;
		sha256_pkg::hash_state_t got;
		msg = '{8'h61, 8'h62, 8'h63};
		run_hash(msg, 1'b0, "abc", got);
		check_digest(got, abc_digest, "abc against known value");
	endtask

	// 56 bytes leaves no room for the length field
	task automatic test_pad_spill();
		sha256_pkg::hash_state_t got;
		run_hash(random_message(56), 1'b1, "56 byte message", got);
	endtask

	// Later blocks arrive while earlier ones compress
	task automatic test_long_stream();
		sha256_pkg::hash_state_t got;
		run_hash(random_message(200), 1'b1, "200 byte message", got);
	endtask

	task automatic test_back_to_back();
		sha256_pkg::hash_state_t got;
		run_hash(random_message(20), 1'b1, "first of two hashes", got);
		run_hash(random_message(70), 1'b1, "second of two hashes", got);
	endtask

	task automatic test_reset_mid_message();
		sha256_pkg::hash_state_t got;
		start_hash();
		drive_message(random_message(40), 1'b1);
		apply_reset();
		run_hash(random_message(64), 1'b1, "hash after reset mid message", got);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog and main sequence

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		fail_now($sformatf("Watchdog expired after %0d cycles before the tests finished",
			watchdog_cycles));
	end

	initial begin
		data_in = '0;
		lfsr = 32'd94729;
		apply_reset();
		test_idle_then_empty();
		test_abc();
		test_pad_spill();
		test_long_stream();
		test_back_to_back();
		test_reset_mid_message();
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verif
hdl/sha256_pkg.sv
hdl/byte_word_fifo.sv
hdl/sha256_msg_schedule.sv
hdl/sha256_compress.sv
hdl/sha256_block_ctrl.sv
hdl/streaming_sha256.sv
verif/streaming_sha256_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the streaming SHA-256 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --top-module streaming_sha256_tb -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vstreaming_sha256_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1
